/* hdl/cache_cfg.svh */
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// Byte address width
`define CACHE_ADDR_W 32

// 64-byte lines
`define CACHE_OFFSET_W 6

// 16 sets
`define CACHE_INDEX_W 4
`define CACHE_SETS (1 << `CACHE_INDEX_W)

// Whatever is left of the address above index and offset
`define CACHE_TAG_W (`CACHE_ADDR_W - `CACHE_INDEX_W - `CACHE_OFFSET_W)

// Associativity, way number and LRU rank share one width
`define CACHE_WAYS 4
`define CACHE_WAY_W 2

// Statistics counters
`define CACHE_CNT_W 16

`endif

/* hdl/cache_pkg.sv */
`include "cache_cfg.svh"

package cache_pkg;

	// Command codes as carried on the trace
	// Code 2 left unused
	typedef enum logic [2:0] {
		CMD_READ       = 3'd0,
		CMD_WRITE      = 3'd1,
		CMD_L2_INVAL   = 3'd3,
		CMD_L2_DATA_RQ = 3'd4,
		CMD_CLR        = 3'd5
	} cmd_e;

	// Address fields
	typedef logic [`CACHE_TAG_W-1:0] tag_t;
	typedef logic [`CACHE_INDEX_W-1:0] index_t;

	// Way number, also used as LRU rank
	typedef logic [`CACHE_WAY_W-1:0] way_t;

	// Statistics count
	typedef logic [`CACHE_CNT_W-1:0] cnt_t;

endpackage

/* hdl/mesi_pkg.sv */
package mesi_pkg;

	import cache_pkg::*;

	// Line coherence state
	typedef enum logic [1:0] {
		MESI_I = 2'b00,
		MESI_S = 2'b01,
		MESI_E = 2'b10,
		MESI_M = 2'b11
	} mesi_e;

	// One stored line, tag in the upper bits
	typedef struct packed {
		tag_t  tag;
		mesi_e state;
	} line_t;

endpackage

/* hdl/lookup_if.sv */
`timescale 1ns/1ps
`include "cache_cfg.svh"

interface lookup_if import cache_pkg::*, mesi_pkg::*; ();

	// Request side, from the controller
	index_t index;
	tag_t   tag;
	logic   upd_en;
	way_t   upd_way;
	mesi_e  upd_state;
	logic   clr;

	// Result side, from the tag store
	logic   hit;
	way_t   hit_way;
	mesi_e  hit_state;
	logic   free_valid;
	way_t   free_way;
	// State of every way in the indexed set
	mesi_e  victim_state_of [`CACHE_WAYS];

	modport ctrl (
		output index, tag, upd_en, upd_way, upd_state, clr,
		input  hit, hit_way, hit_state, free_valid, free_way, victim_state_of
	);

	modport store (
		input  index, tag, upd_en, upd_way, upd_state, clr,
		output hit, hit_way, hit_state, free_valid, free_way, victim_state_of
	);

endinterface

/* hdl/lru_if.sv */
`timescale 1ns/1ps

interface lru_if import cache_pkg::*; ();

	// Set being looked at and the way just used
	index_t index;
	logic   touch;
	way_t   touch_way;
	logic   clr;

	// Rank-0 way of the indexed set
	way_t   victim_way;

	modport ctrl (
		output index, touch, touch_way, clr,
		input  victim_way
	);

	modport lru (
		input  index, touch, touch_way, clr,
		output victim_way
	);

endinterface

/* hdl/tag_store.sv */
`timescale 1ns/1ps
`include "cache_cfg.svh"

module tag_store import cache_pkg::*, mesi_pkg::*; (
	input logic     i_clk,
	input logic     i_rst_n,
	lookup_if.store lk
);

	// One record per set and way
	line_t lines [`CACHE_SETS][`CACHE_WAYS];

	// Per-way match in the indexed set
	logic [`CACHE_WAYS-1:0] way_match;
	logic [`CACHE_WAYS-1:0] way_free;

	// Tag compare, valid only on a live line
	always_comb begin
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			way_free[w]  = (lines[lk.index][w].state == MESI_I);
			way_match[w] = !way_free[w] && (lines[lk.index][w].tag == lk.tag);
		end
	end

	// Hit way, lowest matching way wins
	// Only one way can match in practice
	always_comb begin
		lk.hit       = |way_match;
		lk.hit_way   = '0;
		lk.hit_state = MESI_I;
		for (int w = `CACHE_WAYS - 1; w >= 0; w--) begin
			if (way_match[w]) begin
				lk.hit_way   = way_t'(w);
				lk.hit_state = lines[lk.index][w].state;
			end
		end
	end

	// Lowest Invalid way of the set
	always_comb begin
		lk.free_valid = |way_free;
		lk.free_way   = '0;
		// Descending scan leaves the lowest one
		for (int w = `CACHE_WAYS - 1; w >= 0; w--) begin
			if (way_free[w]) begin
				lk.free_way = way_t'(w);
			end
		end
	end

	// Expose all states of the set
	// Controller picks the one it evicts
	always_comb begin
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			lk.victim_state_of[w] = lines[lk.index][w].state;
		end
	end

	// Line writes and bulk invalidate
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			for (int s = 0; s < `CACHE_SETS; s++) begin
				for (int w = 0; w < `CACHE_WAYS; w++) begin
					lines[s][w].state <= MESI_I;
				end
			end
		end else if (lk.clr) begin
			// CLR drops every line, no writeback
			for (int s = 0; s < `CACHE_SETS; s++) begin
				for (int w = 0; w < `CACHE_WAYS; w++) begin
					lines[s][w].state <= MESI_I;
				end
			end
		end else if (lk.upd_en) begin
			// Tag and state in one write
			lines[lk.index][lk.upd_way].tag   <= lk.tag;
			lines[lk.index][lk.upd_way].state <= lk.upd_state;
		end
	end

endmodule

/* hdl/lru_tracker.sv */
`timescale 1ns/1ps
`include "cache_cfg.svh"

module lru_tracker import cache_pkg::*; (
	input logic i_clk,
	input logic i_rst_n,
	lru_if.lru  lr
);

	// Rank per set and way
	// 0 is least recent, WAYS-1 most recent
	way_t ranks [`CACHE_SETS][`CACHE_WAYS];

	// Current rank of the way being touched
	way_t touch_rank;

	assign touch_rank = ranks[lr.index][lr.touch_way];

	// Victim is the rank-0 way
	always_comb begin
		lr.victim_way = '0;
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			if (ranks[lr.index][w] == '0) begin
				lr.victim_way = way_t'(w);
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			// Rank equals way number
			for (int s = 0; s < `CACHE_SETS; s++) begin
				for (int w = 0; w < `CACHE_WAYS; w++) begin
					ranks[s][w] <= way_t'(w);
				end
			end
		end else if (lr.clr) begin
			// Same start order as after reset
			for (int s = 0; s < `CACHE_SETS; s++) begin
				for (int w = 0; w < `CACHE_WAYS; w++) begin
					ranks[s][w] <= way_t'(w);
				end
			end
		end else if (lr.touch) begin
			for (int w = 0; w < `CACHE_WAYS; w++) begin
				if (way_t'(w) == lr.touch_way) begin
					// Touched way becomes most recent
					ranks[lr.index][w] <= way_t'(`CACHE_WAYS - 1);
				end else if (ranks[lr.index][w] > touch_rank) begin
					// Ways above it slide down one
					ranks[lr.index][w] <= ranks[lr.index][w] - way_t'(1);
				end
			end
		end
	end

endmodule

/* hdl/cache_ctrl.sv */
`timescale 1ns/1ps
`include "cache_cfg.svh"

module cache_ctrl import cache_pkg::*, mesi_pkg::*; (
	input  logic                     i_clk,
	input  logic                     i_rst_n,
	input  logic                     i_cmd_valid,
	input  cmd_e                     i_cmd,
	input  logic [`CACHE_ADDR_W-1:0] i_addr,
	lookup_if.ctrl                   lk,
	lru_if.ctrl                      lr,
	output logic                     o_hit,
	output logic                     o_miss,
	output logic                     o_writeback,
	output cnt_t                     o_read_count,
	output cnt_t                     o_write_count,
	output cnt_t                     o_hit_count,
	output cnt_t                     o_miss_count
);

	// Decoded command
	logic is_rd;
	logic is_wr;
	logic is_acc;
	logic is_inval;
	logic is_data_rq;
	logic is_clr;

	// Way chosen on a miss
	way_t miss_way;
	logic evict_wb;
	logic snoop_wb;

	// Split the address, offset is dropped
	assign lk.tag   = i_addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
	assign lk.index = i_addr[`CACHE_OFFSET_W +: `CACHE_INDEX_W];
	assign lr.index = lk.index;

	always_comb begin
		is_rd      = 1'b0;
		is_wr      = 1'b0;
		is_inval   = 1'b0;
		is_data_rq = 1'b0;
		is_clr     = 1'b0;
		if (i_cmd_valid) begin
			case (i_cmd)
				CMD_READ:       is_rd      = 1'b1;
				CMD_WRITE:      is_wr      = 1'b1;
				CMD_L2_INVAL:   is_inval   = 1'b1;
				CMD_L2_DATA_RQ: is_data_rq = 1'b1;
				CMD_CLR:        is_clr     = 1'b1;
				default:        is_clr     = 1'b0;
			endcase
		end
	end

	assign is_acc = is_rd || is_wr;

	// Empty way first, LRU way otherwise
	assign miss_way = lk.free_valid ? lk.free_way : lr.victim_way;

	// Dirty victim on a miss
	assign evict_wb = is_acc && !lk.hit && (lk.victim_state_of[miss_way] == MESI_M);
	// Snoop hits a dirty line
	assign snoop_wb = is_data_rq && lk.hit && (lk.hit_state == MESI_M);

	// Line update and MESI next state
	always_comb begin
		lk.upd_en    = 1'b0;
		lk.upd_way   = lk.hit ? lk.hit_way : miss_way;
		lk.upd_state = lk.hit_state;
		if (is_wr) begin
			// Any write ends Modified
			lk.upd_en    = 1'b1;
			lk.upd_state = MESI_M;
		end else if (is_rd) begin
			lk.upd_en    = 1'b1;
			// Read fill is Exclusive, read hit keeps state
			lk.upd_state = lk.hit ? lk.hit_state : MESI_E;
		end else if (is_inval || is_data_rq) begin
			// Snoops only act on a matching line
			lk.upd_en    = lk.hit;
			lk.upd_state = MESI_I;
		end
	end

	assign lk.clr = is_clr;

	// LRU follows reads and writes only
	assign lr.touch     = is_acc;
	assign lr.touch_way = lk.upd_way;
	assign lr.clr       = is_clr;

	// Result pulses, one cycle after the command
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			o_hit       <= 1'b0;
			o_miss      <= 1'b0;
			o_writeback <= 1'b0;
		end else begin
			o_hit       <= is_acc && lk.hit;
			o_miss      <= is_acc && !lk.hit;
			o_writeback <= evict_wb || snoop_wb;
		end
	end

	// Statistics
	always_ff @(posedge i_clk) begin
		if (!i_rst_n || is_clr) begin
			o_read_count  <= '0;
			o_write_count <= '0;
			o_hit_count   <= '0;
			o_miss_count  <= '0;
		end else if (is_acc) begin
			if (is_rd) begin
				o_read_count <= o_read_count + cnt_t'(1);
			end
			if (is_wr) begin
				o_write_count <= o_write_count + cnt_t'(1);
			end
			// Hit or miss per access
			if (lk.hit) begin
				o_hit_count <= o_hit_count + cnt_t'(1);
			end else begin
				o_miss_count <= o_miss_count + cnt_t'(1);
			end
		end
	end

endmodule

/* hdl/l1_dcache.sv */
`timescale 1ns/1ps
`include "cache_cfg.svh"

module l1_dcache import cache_pkg::*; (
	input  logic                     i_clk,
	input  logic                     i_rst_n,
	input  logic                     i_cmd_valid,
	input  cmd_e                     i_cmd,
	input  logic [`CACHE_ADDR_W-1:0] i_addr,
	output logic                     o_hit,
	output logic                     o_miss,
	output logic                     o_writeback,
	output cnt_t                     o_read_count,
	output cnt_t                     o_write_count,
	output cnt_t                     o_hit_count,
	output cnt_t                     o_miss_count
);

	// Controller to tag store
	lookup_if lookup_bus ();
	// Controller to LRU ranks
	lru_if lru_bus ();

	tag_store tag_store_inst (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.lk      (lookup_bus.store)
	);

	lru_tracker lru_tracker_inst (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.lr      (lru_bus.lru)
	);

	// Command decode, MESI and counters
	cache_ctrl cache_ctrl_inst (
		.i_clk         (i_clk),
		.i_rst_n       (i_rst_n),
		.i_cmd_valid   (i_cmd_valid),
		.i_cmd         (i_cmd),
		.i_addr        (i_addr),
		.lk            (lookup_bus.ctrl),
		.lr            (lru_bus.ctrl),
		.o_hit         (o_hit),
		.o_miss        (o_miss),
		.o_writeback   (o_writeback),
		.o_read_count  (o_read_count),
		.o_write_count (o_write_count),
		.o_hit_count   (o_hit_count),
		.o_miss_count  (o_miss_count)
	);

endmodule

/* dv/l1_dcache_assert.sv */
`timescale 1ns/1ps

module l1_dcache_assert import cache_pkg::*, mesi_pkg::*; (
	input logic i_clk,
	input logic i_rst_n,
	input logic i_cmd_valid,
	input cmd_e i_cmd,
	input logic o_hit,
	input logic o_miss,
	input logic o_writeback,
	input cnt_t o_read_count,
	input cnt_t o_write_count,
	input cnt_t o_hit_count,
	input cnt_t o_miss_count
);

	// Number of assertion failures so far
	int unsigned assert_errors = 0;

	// Counters only fall after a CLR
	property only_clr_lowers(cnt_t cnt);
		@(posedge i_clk) disable iff (!i_rst_n)
		(cnt < $past(cnt)) |-> $past(i_cmd_valid && i_cmd == CMD_CLR);
	endproperty

	// One lookup result at a time
	hit_miss_excl: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		!(o_hit && o_miss))
	else begin
		$error("o_hit and o_miss high together");
		assert_errors++;
	end

	// Writeback from an eviction or a snoop only
	wb_source: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_writeback |-> (o_miss || $past(i_cmd_valid && i_cmd == CMD_L2_DATA_RQ)))
	else begin
		$error("o_writeback without a miss or an L2_DATA_RQ");
		assert_errors++;
	end

	rd_cnt_drop: assert property (only_clr_lowers(o_read_count))
	else begin
		$error("read count dropped without CLR");
		assert_errors++;
	end

	wr_cnt_drop: assert property (only_clr_lowers(o_write_count))
	else begin
		$error("write count dropped without CLR");
		assert_errors++;
	end

	hit_cnt_drop: assert property (only_clr_lowers(o_hit_count))
	else begin
		$error("hit count dropped without CLR");
		assert_errors++;
	end

	miss_cnt_drop: assert property (only_clr_lowers(o_miss_count))
	else begin
		$error("miss count dropped without CLR");
		assert_errors++;
	end

endmodule

bind l1_dcache l1_dcache_assert l1_dcache_assert_inst (
	.i_clk         (i_clk),
	.i_rst_n       (i_rst_n),
	.i_cmd_valid   (i_cmd_valid),
	.i_cmd         (i_cmd),
	.o_hit         (o_hit),
	.o_miss        (o_miss),
	.o_writeback   (o_writeback),
	.o_read_count  (o_read_count),
	.o_write_count (o_write_count),
	.o_hit_count   (o_hit_count),
	.o_miss_count  (o_miss_count)
);

/* dv/l1_dcache_tb.sv */
`timescale 1ns/1ps
`include "cache_cfg.svh"

module l1_dcache_tb import cache_pkg::*;;

	// One table row, a command and its expected pulses
	typedef struct {
		logic                       valid;
		cmd_e                       cmd;
		tag_t                       tag;
		index_t                     index;
		logic [`CACHE_OFFSET_W-1:0] offset;
		logic                       hit;
		logic                       miss;
		logic                       wb;
	} row_t;

	logic                     i_clk;
	logic                     i_rst_n;
	logic                     i_cmd_valid;
	cmd_e                     i_cmd;
	logic [`CACHE_ADDR_W-1:0] i_addr;
	logic                     o_hit;
	logic                     o_miss;
	logic                     o_writeback;
	cnt_t                     o_read_count;
	cnt_t                     o_write_count;
	cnt_t                     o_hit_count;
	cnt_t                     o_miss_count;

	row_t rows [$];
	integer seed = 601;
	int errors = 0;
	int checks = 0;
	int cycles = 0;
	int cycle_limit = 1000;
	// Expected totals since the last CLR
	int exp_rd;
	int exp_wr;
	int exp_hit;
	int exp_miss;

	l1_dcache l1_dcache_inst (.*);

	// 40 ns clock
	initial i_clk = 1'b0;
	always #20 i_clk = ~i_clk;

	// Hang guard
	always @(posedge i_clk) begin
		cycles++;
		if (cycles >= cycle_limit) begin
			$display("Run timed out after %0d cycles", cycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	task automatic check_value(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic add_row(input cmd_e cmd, input int tag, input int index, input int offset,
			input logic hit, input logic miss, input logic wb);
		rows.push_back('{1'b1, cmd, tag_t'(tag), index_t'(index), offset[5:0], hit, miss, wb});
	endtask

	// No command, address noise only
	task automatic add_idle();
		logic [31:0] r;
		r = $random(seed);
		rows.push_back('{1'b0, CMD_READ, tag_t'(r >> 8), index_t'(r >> 4), r[5:0],
			1'b0, 1'b0, 1'b0});
	endtask

	task automatic drive_row(input int i);
		i_cmd_valid = rows[i].valid;
		i_cmd       = rows[i].cmd;
		i_addr      = {rows[i].tag, rows[i].index, rows[i].offset};
	endtask

	// Pulses of row i are visible in the half cycle after its edge
	task automatic check_row(input int i);
		check_value($sformatf("row %0d o_hit", i), 32'(o_hit), 32'(rows[i].hit));
		check_value($sformatf("row %0d o_miss", i), 32'(o_miss), 32'(rows[i].miss));
		check_value($sformatf("row %0d o_writeback", i), 32'(o_writeback), 32'(rows[i].wb));
		if (rows[i].valid && rows[i].cmd == CMD_CLR) begin
			check_value("read count after CLR", 32'(o_read_count), 0);
			check_value("write count after CLR", 32'(o_write_count), 0);
			check_value("hit count after CLR", 32'(o_hit_count), 0);
			check_value("miss count after CLR", 32'(o_miss_count), 0);
		end
	endtask

	task automatic build_table();
		// Read miss, then hit on the same line
		add_row(CMD_READ, 'h10, 1, 'h00, 0, 1, 0);
		add_row(CMD_READ, 'h10, 1, 'h24, 1, 0, 0);
		add_idle();
		// Write allocate, then dirty eviction on the fourth new tag
		add_row(CMD_WRITE, 'h20, 2, 'h00, 0, 1, 0);
		add_row(CMD_WRITE, 'h20, 2, 'h08, 1, 0, 0);
		add_row(CMD_READ, 'h21, 2, 'h00, 0, 1, 0);
		add_row(CMD_READ, 'h22, 2, 'h00, 0, 1, 0);
		add_row(CMD_READ, 'h23, 2, 'h00, 0, 1, 0);
		add_row(CMD_READ, 'h24, 2, 'h00, 0, 1, 1);
		add_row(CMD_READ, 'h20, 2, 'h00, 0, 1, 0);
		add_idle();
		// LRU order in set 3
		add_row(CMD_READ, 'h30, 3, 'h00, 0, 1, 0);
		add_row(CMD_READ, 'h31, 3, 'h00, 0, 1, 0);
		add_row(CMD_READ, 'h32, 3, 'h00, 0, 1, 0);
		add_row(CMD_READ, 'h33, 3, 'h00, 0, 1, 0);
		add_row(CMD_READ, 'h30, 3, 'h10, 1, 0, 0);
		add_row(CMD_READ, 'h34, 3, 'h00, 0, 1, 0);
		add_row(CMD_READ, 'h31, 3, 'h00, 0, 1, 0);
		add_row(CMD_READ, 'h30, 3, 'h20, 1, 0, 0);
		add_idle();
		// Snoops from L2
		add_row(CMD_READ, 'h40, 4, 'h00, 0, 1, 0);
		add_row(CMD_L2_INVAL, 'h40, 4, 'h00, 0, 0, 0);
		add_row(CMD_READ, 'h40, 4, 'h00, 0, 1, 0);
		add_row(CMD_WRITE, 'h41, 4, 'h00, 0, 1, 0);
		add_row(CMD_L2_DATA_RQ, 'h41, 4, 'h00, 0, 0, 1);
		add_row(CMD_READ, 'h41, 4, 'h00, 0, 1, 0);
		add_row(CMD_L2_DATA_RQ, 'h40, 4, 'h00, 0, 0, 0);
		add_row(CMD_READ, 'h40, 4, 'h00, 0, 1, 0);
		add_idle();
		// Clear, old lines gone
		add_row(CMD_CLR, 'h00, 0, 'h00, 0, 0, 0);
		add_row(CMD_READ, 'h10, 1, 'h00, 0, 1, 0);
		add_row(CMD_READ, 'h24, 2, 'h00, 0, 1, 0);
		add_row(CMD_WRITE, 'h30, 3, 'h00, 0, 1, 0);
		add_row(CMD_READ, 'h30, 3, 'h3f, 1, 0, 0);
	endtask

	initial begin
		i_rst_n     = 1'b0;
		i_cmd_valid = 1'b0;
		i_cmd       = CMD_READ;
		i_addr      = '0;
		build_table();
		cycle_limit = 5 + rows.size() + 20;
		repeat (5) @(negedge i_clk);
		i_rst_n = 1'b1;

		for (int i = 0; i < rows.size(); i++) begin
			@(negedge i_clk);
			if (i > 0) begin
				check_row(i - 1);
			end
			drive_row(i);
		end
		@(negedge i_clk);
		check_row(rows.size() - 1);
		i_cmd_valid = 1'b0;

		// Totals from the rows after the last CLR
		exp_rd   = 0;
		exp_wr   = 0;
		exp_hit  = 0;
		exp_miss = 0;
		foreach (rows[i]) begin
			if (rows[i].valid && rows[i].cmd == CMD_CLR) begin
				exp_rd   = 0;
				exp_wr   = 0;
				exp_hit  = 0;
				exp_miss = 0;
			end
			if (rows[i].valid && rows[i].cmd == CMD_READ) exp_rd++;
			if (rows[i].valid && rows[i].cmd == CMD_WRITE) exp_wr++;
			if (rows[i].hit) exp_hit++;
			if (rows[i].miss) exp_miss++;
		end
		check_value("read count", 32'(o_read_count), exp_rd);
		check_value("write count", 32'(o_write_count), exp_wr);
		check_value("hit count", 32'(o_hit_count), exp_hit);
		check_value("miss count", 32'(o_miss_count), exp_miss);

		errors += l1_dcache_inst.l1_dcache_assert_inst.assert_errors;
		$display("Checks: %0d, errors: %0d (assertions: %0d)", checks, errors,
			l1_dcache_inst.l1_dcache_assert_inst.assert_errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* flist.f */
+incdir+hdl
hdl/cache_pkg.sv
hdl/mesi_pkg.sv
hdl/lookup_if.sv
hdl/lru_if.sv
hdl/tag_store.sv
hdl/lru_tracker.sv
hdl/cache_ctrl.sv
hdl/l1_dcache.sv
dv/l1_dcache_assert.sv
dv/l1_dcache_tb.sv

/* Bender.yml */
package:
  name: l1_dcache

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/cache_pkg.sv
      - hdl/mesi_pkg.sv
      - hdl/lookup_if.sv
      - hdl/lru_if.sv
      - hdl/tag_store.sv
      - hdl/lru_tracker.sv
      - hdl/cache_ctrl.sv
      - hdl/l1_dcache.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - dv/l1_dcache_assert.sv
      - dv/l1_dcache_tb.sv
